// File: rtl/beam_sort_pkg.sv
//--------------------------------------------------------------------------
// Shared definitions for the beam sorter
// Index and score width, APB widths and register map
// Small helper types and the controller state enum
//--------------------------------------------------------------------------
`default_nettype none

package beam_sort_pkg;

    // Widths
    localparam int IDX_W   = 8;
    localparam int APB_AW  = 12;
    localparam int APB_DW  = 32;
    localparam int SLOT_W  = 4;
    localparam int FCNT_W  = 16;

    // APB register map, byte addresses of 32-bit words
    localparam logic [APB_AW-1:0] ADDR_LIMIT     = 12'h000;
    localparam logic [APB_AW-1:0] ADDR_STATUS    = 12'h004;
    localparam logic [APB_AW-1:0] ADDR_BEAM_BASE = 12'h100;

    // Bit position of the original index inside a beam entry
    localparam int IDX_LSB = 16;

    typedef logic [IDX_W-1:0]  idx_t;
    typedef logic [SLOT_W-1:0] slot_t;

    typedef enum logic [1:0] {IDLE, RANK, SCATTER, STORE} sort_state_t;

    // Counter width for n states, at least one bit
    function automatic int cnt_w(int n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

endpackage

`default_nettype wire

// File: rtl/sort_ctrl.sv
//--------------------------------------------------------------------------
// Sort controller FSM
// Accepts a frame, then walks through rank, scatter and store
// Issues the phase enables and the one-cycle frame done pulse
//--------------------------------------------------------------------------
`default_nettype none

module sort_ctrl (
    input  wire   i_clk,
    input  wire   i_reset,
    input  wire   i_valid,
    input  wire   i_last_group,
    output logic  o_ready,
    output logic  o_capture,
    output logic  o_rank_en,
    output logic  o_scatter_en,
    output logic  o_store_en,
    output logic  o_frame_done
);

    beam_sort_pkg::sort_state_t state_q;
    beam_sort_pkg::sort_state_t state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            beam_sort_pkg::IDLE: begin
                if (i_valid) begin
                    state_d = beam_sort_pkg::RANK;
                end
            end
            beam_sort_pkg::RANK: begin
                // Leave after the last lane group is scored
                if (i_last_group) begin
                    state_d = beam_sort_pkg::SCATTER;
                end
            end
            beam_sort_pkg::SCATTER: state_d = beam_sort_pkg::STORE;
            beam_sort_pkg::STORE:   state_d = beam_sort_pkg::IDLE;
            default:                state_d = beam_sort_pkg::IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state_q      <= beam_sort_pkg::IDLE;
            o_frame_done <= 1'b0;
        end else begin
            state_q      <= state_d;
            o_frame_done <= o_store_en;
        end
    end

    // One-hot phase decode
    assign o_ready      = (state_q == beam_sort_pkg::IDLE);
    assign o_capture    = o_ready & i_valid;
    assign o_rank_en    = (state_q == beam_sort_pkg::RANK);
    assign o_scatter_en = (state_q == beam_sort_pkg::SCATTER);
    assign o_store_en   = (state_q == beam_sort_pkg::STORE);

endmodule

`default_nettype wire

// File: rtl/group_counter.sv
//--------------------------------------------------------------------------
// Rank group counter, store slot pointer and frame counter
// Slot wraps at the APB limit, frame count wraps at 16 bits
//--------------------------------------------------------------------------
`default_nettype none

module group_counter #(
    parameter int COL   = 16,
    parameter int LANES = 4,
    parameter int DEPTH = 8
) (
    input  wire                                            i_clk,
    input  wire                                            i_reset,
    input  wire                                            i_capture,
    input  wire                                            i_rank_en,
    input  wire                                            i_store_en,
    input  wire  [beam_sort_pkg::SLOT_W-1:0]               i_limit,
    output logic [beam_sort_pkg::cnt_w(COL/LANES)-1:0]     o_group,
    output logic                                           o_last_group,
    output logic [beam_sort_pkg::SLOT_W-1:0]               o_slot,
    output logic [beam_sort_pkg::FCNT_W-1:0]               o_frame_count
);

    localparam int NG = COL / LANES;
    localparam int GW = beam_sort_pkg::cnt_w(NG);

    logic slot_wrap;

    assign o_last_group = i_rank_en && (o_group == GW'(NG - 1));

    assign slot_wrap = (o_slot >= i_limit);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_group <= '0;
        end else if (i_capture) begin
            o_group <= '0;
        end else if (i_rank_en) begin
            o_group <= o_last_group ? '0 : o_group + 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_slot        <= '0;
            o_frame_count <= '0;
        end else if (i_store_en) begin
            o_slot        <= slot_wrap ? '0 : o_slot + 1'b1;
            o_frame_count <= o_frame_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: rtl/rank_lanes.sv
//--------------------------------------------------------------------------
// Frame capture and lane-parallel ranking
// Each rank cycle scores LANES elements against the whole frame
// Score = count of larger values plus equal values at lower index
//--------------------------------------------------------------------------
`default_nettype none

module rank_lanes #(
    parameter int COL   = 16,
    parameter int IW    = 16,
    parameter int LANES = 4
) (
    input  wire                                            i_clk,
    input  wire  [COL-1:0][IW-1:0]                         i_frame,
    input  wire                                            i_capture,
    input  wire                                            i_rank_en,
    input  wire  [beam_sort_pkg::cnt_w(COL/LANES)-1:0]     i_group,
    output logic [COL-1:0][IW-1:0]                         o_frame,
    output logic [COL-1:0][beam_sort_pkg::IDX_W-1:0]       o_scores
);

    localparam int EW = beam_sort_pkg::cnt_w(COL);

    logic [COL-1:0][IW-1:0]                    frame_q;
    logic [COL-1:0][beam_sort_pkg::IDX_W-1:0]  scores_q;
    logic [EW-1:0]                             lane_elem  [LANES];
    beam_sort_pkg::idx_t                       lane_score [LANES];

    //----------------------------------------------------------------------
    // Score compare, one element per lane
    //----------------------------------------------------------------------
    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            lane_elem[l]  = EW'(int'(i_group) * LANES + l);
            lane_score[l] = '0;
            for (int j = 0; j < COL; j++) begin
                // Ties go to the lower index
                if ((frame_q[j] > frame_q[lane_elem[l]]) ||
                    ((frame_q[j] == frame_q[lane_elem[l]]) &&
                     (EW'(j) < lane_elem[l]))) begin
                    lane_score[l] = lane_score[l] + 1'b1;
                end
            end
        end
    end

    //----------------------------------------------------------------------
    // Frame latch and score array
    //----------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_capture) begin
            frame_q <= i_frame;
        end
        if (i_rank_en) begin
            for (int l = 0; l < LANES; l++) begin
                scores_q[lane_elem[l]] <= lane_score[l];
            end
        end
    end

    assign o_frame  = frame_q;
    assign o_scores = scores_q;

endmodule

`default_nettype wire

// File: rtl/beam_scatter.sv
//--------------------------------------------------------------------------
// Beam scatter
// Scores form a permutation, so each top position gets one element
//--------------------------------------------------------------------------
`default_nettype none

module beam_scatter #(
    parameter int COL   = 16,
    parameter int IW    = 16,
    parameter int NBEAM = 4
) (
    input  wire                                         i_clk,
    input  wire                                         i_scatter_en,
    input  wire  [COL-1:0][IW-1:0]                      i_frame,
    input  wire  [COL-1:0][beam_sort_pkg::IDX_W-1:0]    i_scores,
    output logic [NBEAM-1:0][IW-1:0]                    o_beam_data,
    output logic [NBEAM-1:0][beam_sort_pkg::IDX_W-1:0]  o_beam_index
);

    localparam int SW = beam_sort_pkg::cnt_w(NBEAM);

    logic [NBEAM-1:0][IW-1:0]                    data_q;
    logic [NBEAM-1:0][beam_sort_pkg::IDX_W-1:0]  index_q;

    // Only the NBEAM best positions are kept
    always_ff @(posedge i_clk) begin
        if (i_scatter_en) begin
            for (int i = 0; i < COL; i++) begin
                if (i_scores[i] < NBEAM) begin
                    data_q[i_scores[i][SW-1:0]]  <= i_frame[i];
                    index_q[i_scores[i][SW-1:0]] <= beam_sort_pkg::idx_t'(i);
                end
            end
        end
    end

    assign o_beam_data  = data_q;
    assign o_beam_index = index_q;

endmodule

`default_nettype wire

// File: rtl/beam_store.sv
//--------------------------------------------------------------------------
// Beam store with APB slave
// DEPTH x NBEAM entry register array, one slot per frame
// Limit register and read decode of limit, status and entries
//--------------------------------------------------------------------------
`default_nettype none

module beam_store #(
    parameter int IW    = 16,
    parameter int NBEAM = 4,
    parameter int DEPTH = 8
) (
    input  wire                                         i_clk,
    input  wire                                         i_reset,
    input  wire                                         i_store_en,
    input  wire  [beam_sort_pkg::SLOT_W-1:0]            i_slot,
    input  wire  [NBEAM-1:0][IW-1:0]                    i_beam_data,
    input  wire  [NBEAM-1:0][beam_sort_pkg::IDX_W-1:0]  i_beam_index,
    input  wire  [beam_sort_pkg::FCNT_W-1:0]            i_frame_count,
    input  wire                                         i_psel,
    input  wire                                         i_penable,
    input  wire                                         i_pwrite,
    input  wire  [beam_sort_pkg::APB_AW-1:0]            i_paddr,
    input  wire  [beam_sort_pkg::APB_DW-1:0]            i_pwdata,
    output logic [beam_sort_pkg::APB_DW-1:0]            o_prdata,
    output logic [beam_sort_pkg::SLOT_W-1:0]            o_limit
);

    localparam int NENT = DEPTH * NBEAM;
    localparam int EW   = beam_sort_pkg::cnt_w(NENT);

    logic [IW-1:0]                     ent_data  [NENT];
    beam_sort_pkg::idx_t               ent_index [NENT];
    logic [beam_sort_pkg::SLOT_W-1:0]  limit_q;
    logic                              apb_access;
    logic                              apb_write;
    logic [beam_sort_pkg::APB_AW-1:0]  beam_off;
    logic [beam_sort_pkg::APB_AW-3:0]  entry;
    logic                              entry_hit;

    //----------------------------------------------------------------------
    // Entry array, flat index slot * NBEAM + rank
    //----------------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_store_en) begin
            for (int k = 0; k < NBEAM; k++) begin
                ent_data[EW'(int'(i_slot) * NBEAM + k)]  <= i_beam_data[k];
                ent_index[EW'(int'(i_slot) * NBEAM + k)] <= i_beam_index[k];
            end
        end
    end

    //----------------------------------------------------------------------
    // APB write side
    //----------------------------------------------------------------------
    assign apb_access = i_psel & i_penable;
    assign apb_write  = apb_access & i_pwrite;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            limit_q <= beam_sort_pkg::slot_t'(DEPTH - 1);
        end else if (apb_write && (i_paddr == beam_sort_pkg::ADDR_LIMIT)) begin
            // Clamp to the last slot
            if (i_pwdata >= DEPTH) begin
                limit_q <= beam_sort_pkg::slot_t'(DEPTH - 1);
            end else begin
                limit_q <= i_pwdata[beam_sort_pkg::SLOT_W-1:0];
            end
        end
    end

    assign o_limit = limit_q;

    //----------------------------------------------------------------------
    // APB read decode, zero outside a read access
    //----------------------------------------------------------------------
    assign beam_off  = i_paddr - beam_sort_pkg::ADDR_BEAM_BASE;
    assign entry     = beam_off[beam_sort_pkg::APB_AW-1:2];
    assign entry_hit = (i_paddr >= beam_sort_pkg::ADDR_BEAM_BASE) &&
                       (i_paddr[1:0] == 2'b00) && (int'(entry) < NENT);

    always_comb begin
        o_prdata = '0;
        if (apb_access && !i_pwrite) begin
            if (i_paddr == beam_sort_pkg::ADDR_LIMIT) begin
                o_prdata[beam_sort_pkg::SLOT_W-1:0] = limit_q;
            end else if (i_paddr == beam_sort_pkg::ADDR_STATUS) begin
                o_prdata[beam_sort_pkg::FCNT_W-1:0] = i_frame_count;
            end else if (entry_hit) begin
                o_prdata[IW-1:0] = ent_data[EW'(entry)];
                o_prdata[beam_sort_pkg::IDX_LSB +: beam_sort_pkg::IDX_W] =
                    ent_index[EW'(entry)];
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/beam_sort_top.sv
//--------------------------------------------------------------------------
// Beam sorter top level
// Frame valid/ready input, APB host access to stored beams
// Controller, counters, ranking, scatter and store instances
//--------------------------------------------------------------------------
`default_nettype none

module beam_sort_top #(
    parameter int COL   = 16,
    parameter int IW    = 16,
    parameter int LANES = 4,
    parameter int NBEAM = 4,
    parameter int DEPTH = 8
) (
    input  wire                                i_clk,
    input  wire                                i_reset,
    input  wire                                i_valid,
    input  wire  [COL-1:0][IW-1:0]             i_frame,
    input  wire                                i_psel,
    input  wire                                i_penable,
    input  wire                                i_pwrite,
    input  wire  [beam_sort_pkg::APB_AW-1:0]   i_paddr,
    input  wire  [beam_sort_pkg::APB_DW-1:0]   i_pwdata,
    output logic                               o_ready,
    output logic                               o_frame_done,
    output logic [beam_sort_pkg::APB_DW-1:0]   o_prdata
);

    logic                                        capture;
    logic                                        rank_en;
    logic                                        scatter_en;
    logic                                        store_en;
    logic                                        last_group;
    logic [beam_sort_pkg::cnt_w(COL/LANES)-1:0]  group;
    logic [beam_sort_pkg::SLOT_W-1:0]            slot;
    logic [beam_sort_pkg::SLOT_W-1:0]            limit;
    logic [beam_sort_pkg::FCNT_W-1:0]            frame_count;
    logic [COL-1:0][IW-1:0]                      frame_q;
    logic [COL-1:0][beam_sort_pkg::IDX_W-1:0]    scores;
    logic [NBEAM-1:0][IW-1:0]                    beam_data;
    logic [NBEAM-1:0][beam_sort_pkg::IDX_W-1:0]  beam_index;

    sort_ctrl u_ctrl (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_valid      (i_valid),
        .i_last_group (last_group),
        .o_ready      (o_ready),
        .o_capture    (capture),
        .o_rank_en    (rank_en),
        .o_scatter_en (scatter_en),
        .o_store_en   (store_en),
        .o_frame_done (o_frame_done)
    );

    group_counter #(.COL(COL), .LANES(LANES), .DEPTH(DEPTH)) u_count (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_capture     (capture),
        .i_rank_en     (rank_en),
        .i_store_en    (store_en),
        .i_limit       (limit),
        .o_group       (group),
        .o_last_group  (last_group),
        .o_slot        (slot),
        .o_frame_count (frame_count)
    );

    rank_lanes #(.COL(COL), .IW(IW), .LANES(LANES)) u_rank (
        .i_clk     (i_clk),
        .i_frame   (i_frame),
        .i_capture (capture),
        .i_rank_en (rank_en),
        .i_group   (group),
        .o_frame   (frame_q),
        .o_scores  (scores)
    );

    beam_scatter #(.COL(COL), .IW(IW), .NBEAM(NBEAM)) u_scatter (
        .i_clk        (i_clk),
        .i_scatter_en (scatter_en),
        .i_frame      (frame_q),
        .i_scores     (scores),
        .o_beam_data  (beam_data),
        .o_beam_index (beam_index)
    );

    beam_store #(.IW(IW), .NBEAM(NBEAM), .DEPTH(DEPTH)) u_store (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_store_en    (store_en),
        .i_slot        (slot),
        .i_beam_data   (beam_data),
        .i_beam_index  (beam_index),
        .i_frame_count (frame_count),
        .i_psel        (i_psel),
        .i_penable     (i_penable),
        .i_pwrite      (i_pwrite),
        .i_paddr       (i_paddr),
        .i_pwdata      (i_pwdata),
        .o_prdata      (o_prdata),
        .o_limit       (limit)
    );

endmodule

`default_nettype wire

// File: testbench/beam_sort_asserts.sv
//--------------------------------------------------------------------------
// Concurrent assertions on the frame handshake timing
// Bound into the beam sorter top level
//--------------------------------------------------------------------------
`default_nettype none

module beam_sort_asserts #(
    parameter int COL   = 16,
    parameter int LANES = 4
) (
    input wire i_clk,
    input wire i_reset,
    input wire i_valid,
    input wire i_ready,
    input wire i_frame_done
);

    // Edges from acceptance to the done pulse
    localparam int DONE_LAG = COL / LANES + 2;

    logic accept;

    assign accept = i_valid && i_ready;

    a_done_pulse: assert property (@(posedge i_clk) disable iff (i_reset)
        i_frame_done |=> !i_frame_done)
        else $error("frame done held longer than one cycle");

    a_busy_after_accept: assert property (@(posedge i_clk) disable iff (i_reset)
        accept |=> !i_ready)
        else $error("ready still high the cycle after acceptance");

    // Sampled values trail the register update by one edge
    a_done_after_accept: assert property (@(posedge i_clk) disable iff (i_reset)
        $past(accept, DONE_LAG + 1) |-> i_frame_done)
        else $error("frame done missing after acceptance");

    a_done_needs_accept: assert property (@(posedge i_clk) disable iff (i_reset)
        $rose(i_frame_done) |-> $past(accept, DONE_LAG + 1))
        else $error("frame done without a matching acceptance");

endmodule

bind beam_sort_top beam_sort_asserts #(.COL(COL), .LANES(LANES)) u_asserts (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_valid      (i_valid),
    .i_ready      (o_ready),
    .i_frame_done (o_frame_done)
);

`default_nettype wire

// File: testbench/tb_beam_sort.sv
//--------------------------------------------------------------------------
// Beam sorter testbench
// Random frames on the valid/ready input, APB readback of stored beams,
// limit register and frame count, all checked against a model
//--------------------------------------------------------------------------
`default_nettype none

module tb_beam_sort;

    localparam int COL     = 16;
    localparam int IW      = 16;
    localparam int LANES   = 4;
    localparam int NBEAM   = 4;
    localparam int DEPTH   = 8;
    localparam int NG      = COL / LANES;
    localparam int FRAMES  = 27;
    localparam int TIMEOUT = FRAMES * (NG + 2 + 40) + 1000;

    logic                              clk = 1'b0;
    logic                              reset;
    logic                              valid;
    logic [COL-1:0][IW-1:0]            frame;
    logic                              psel;
    logic                              penable;
    logic                              pwrite;
    logic [beam_sort_pkg::APB_AW-1:0]  paddr;
    logic [beam_sort_pkg::APB_DW-1:0]  pwdata;
    wire                               ready;
    wire                               frame_done;
    wire  [beam_sort_pkg::APB_DW-1:0]  prdata;

    // Model state
    int m_slot;
    int m_limit;
    int m_count;
    int exp_data  [NBEAM];
    int exp_index [NBEAM];
    int frame_num;
    int checks;
    int errors;

    always #4 clk = ~clk;

    beam_sort_top #(
        .COL(COL), .IW(IW), .LANES(LANES), .NBEAM(NBEAM), .DEPTH(DEPTH)
    ) dut (
        .i_clk        (clk),
        .i_reset      (reset),
        .i_valid      (valid),
        .i_frame      (frame),
        .i_psel       (psel),
        .i_penable    (penable),
        .i_pwrite     (pwrite),
        .i_paddr      (paddr),
        .i_pwdata     (pwdata),
        .o_ready      (ready),
        .o_frame_done (frame_done),
        .o_prdata     (prdata)
    );

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("ERROR at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
        end
    endtask

    task automatic report_test(input string name, input int mark);
        if (errors == mark) begin
            $display("Test %s: ok", name);
        end else begin
            $display("Test %s: %0d errors", name, errors - mark);
        end
    endtask

    //----------------------------------------------------------------------
    // APB master, one idle cycle between transfers
    //----------------------------------------------------------------------
    task automatic apb_access(input logic wr, input logic [11:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        // Read data is stable in the low half of the access cycle
        #2;
        rdata = prdata;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic read_check(input logic [11:0] addr, input int exp, input string name);
        logic [31:0] rd;
        apb_access(1'b0, addr, 32'h0, rd);
        compare(name, exp, rd);
    endtask

    task automatic write_limit(input int value);
        logic [31:0] rd;
        apb_access(1'b1, beam_sort_pkg::ADDR_LIMIT, value, rd);
        m_limit = (value >= DEPTH) ? DEPTH - 1 : value;
        read_check(beam_sort_pkg::ADDR_LIMIT, m_limit, "limit register");
    endtask

    function automatic logic [COL-1:0][IW-1:0] random_frame(input bit narrow);
        logic [COL-1:0][IW-1:0] f;
        for (int i = 0; i < COL; i++) begin
            f[i] = narrow ? IW'($urandom_range(3, 0)) : IW'($urandom);
        end
        return f;
    endfunction

    // Sorted order by repeated selection, lowest index first among equals
    task automatic model_expect(input logic [COL-1:0][IW-1:0] f);
        bit used [COL];
        int best;
        for (int i = 0; i < COL; i++) begin
            used[i] = 1'b0;
        end
        for (int k = 0; k < NBEAM; k++) begin
            best = -1;
            for (int i = 0; i < COL; i++) begin
                if (!used[i] && (best < 0 || f[i] > f[best])) begin
                    best = i;
                end
            end
            used[best]   = 1'b1;
            exp_data[k]  = f[best];
            exp_index[k] = best;
        end
    endtask

    //----------------------------------------------------------------------
    // One frame: handshake, latency, stored beams, frame count
    //----------------------------------------------------------------------
    task automatic run_frame();
        logic [COL-1:0][IW-1:0] sent;
        logic [31:0]            rd;
        int                     lag;
        sent = random_frame(frame_num % 2 == 0);
        model_expect(sent);
        @(negedge clk);
        valid = 1'b1;
        frame = sent;
        while (!ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        // Valid stays high with other data while the frame is busy
        @(negedge clk);
        frame = random_frame(1'b0);
        lag   = 0;
        while (!frame_done && lag < 4 * NG + 8) begin
            compare("o_ready while busy", 0, ready);
            @(negedge clk);
            lag++;
        end
        valid = 1'b0;
        assert (frame_done) else begin
            errors++;
            $display("Frame %0d never signalled done", frame_num);
        end
        compare("o_frame_done latency", NG + 2, lag);
        compare("o_ready at frame done", 1, ready);
        for (int k = 0; k < NBEAM; k++) begin
            apb_access(1'b0, beam_sort_pkg::ADDR_BEAM_BASE + 4 * (m_slot * NBEAM + k),
                       32'h0, rd);
            compare($sformatf("beam data slot %0d rank %0d", m_slot, k),
                    exp_data[k], rd[IW-1:0]);
            compare($sformatf("beam index slot %0d rank %0d", m_slot, k),
                    exp_index[k], rd[31:beam_sort_pkg::IDX_LSB]);
        end
        m_count = (m_count + 1) % 65536;
        m_slot  = (m_slot >= m_limit) ? 0 : m_slot + 1;
        read_check(beam_sort_pkg::ADDR_STATUS, m_count, "status frame count");
        frame_num++;
    endtask

    initial begin
        int mark;
        logic [31:0] rd;
        void'($urandom(51));
        reset     = 1'b1;
        valid     = 1'b0;
        frame     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        m_slot    = 0;
        m_limit   = DEPTH - 1;
        m_count   = 0;
        frame_num = 0;
        checks    = 0;
        errors    = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        mark = errors;
        compare("o_ready after reset", 1, ready);
        compare("o_frame_done after reset", 0, frame_done);
        read_check(beam_sort_pkg::ADDR_LIMIT, DEPTH - 1, "limit after reset");
        read_check(beam_sort_pkg::ADDR_STATUS, 0, "status after reset");
        report_test("reset state", mark);

        mark = errors;
        for (int n = 0; n < 10; n++) begin
            run_frame();
        end
        report_test("frames at default limit", mark);

        mark = errors;
        write_limit(2);
        for (int n = 0; n < 5; n++) begin
            run_frame();
        end
        // Above the last slot, stored as DEPTH-1
        write_limit(DEPTH + 5);
        for (int n = 0; n < 9; n++) begin
            run_frame();
        end
        write_limit(0);
        for (int n = 0; n < 3; n++) begin
            run_frame();
        end
        report_test("slot wrap after limit writes", mark);

        mark = errors;
        apb_access(1'b1, beam_sort_pkg::ADDR_STATUS, 32'hFFFF, rd);
        read_check(beam_sort_pkg::ADDR_STATUS, m_count, "status after write");
        read_check(12'h008, 0, "unmapped 0x008");
        read_check(12'h0FC, 0, "unmapped 0x0FC");
        read_check(beam_sort_pkg::ADDR_BEAM_BASE + 4 * DEPTH * NBEAM, 0, "past last entry");
        read_check(beam_sort_pkg::ADDR_BEAM_BASE + 2, 0, "misaligned entry");
        read_check(12'hFFC, 0, "unmapped 0xFFC");
        report_test("status and unmapped reads", mark);

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (TIMEOUT) @(posedge clk);
        $display("Run timed out after %0d clock cycles", TIMEOUT);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
rtl/beam_sort_pkg.sv
rtl/sort_ctrl.sv
rtl/group_counter.sv
rtl/rank_lanes.sv
rtl/beam_scatter.sv
rtl/beam_store.sv
rtl/beam_sort_top.sv
testbench/beam_sort_asserts.sv
testbench/tb_beam_sort.sv

// File: run.sh
#!/bin/sh
# Compile and run the beam sorter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module tb_beam_sort
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

out=$(./obj_dir/Vtb_beam_sort)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
echo "Pass message not found"
exit 1
